// ==== verilog/trace_cfg.svh ====
////////////////////////////////////////
// Build-time sizes of the retirement tracer
////////////////////////////////////////

`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// Width of each per-class event counter
// 16 bits keeps saturation reachable in short runs
`define TRACE_CNT_WIDTH 16

// Width of the free-running cycle stamp
`define TRACE_CYCLE_WIDTH 32

// Number of instruction classes, matches instr_class_e
`define TRACE_NUM_CLASSES 10

`endif

// ==== verilog/rv_instr_pkg.sv ====
////////////////////////////////////////
// RV32IM encodings and instruction classes
////////////////////////////////////////

`default_nettype none

package rv_instr_pkg;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////
  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;
  localparam logic [6:0] OPC_MISCMEM = 7'b0001111;

  // funct7 field values
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // funct3 values with extra encoding rules
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
  localparam logic [2:0] FUNCT3_PRIV    = 3'b000;
  localparam logic [2:0] FUNCT3_FENCE   = 3'b000;

  // Privileged words, fully encoded
  localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
  localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;
  localparam logic [31:0] INSTR_DRET   = 32'h7b20_0073;
  localparam logic [31:0] INSTR_WFI    = 32'h1050_0073;

  ////////////////////////////////////////
  // Instruction classes, one counter each
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU     = 4'd0,
    UPPER   = 4'd1,
    JUMP    = 4'd2,
    BRANCH  = 4'd3,
    LOAD    = 4'd4,
    STORE   = 4'd5,
    CSR     = 4'd6,
    SYSTEM  = 4'd7,
    MULDIV  = 4'd8,
    INVALID = 4'd9
  } instr_class_e;

endpackage

`default_nettype wire

// ==== verilog/trace_pkg.sv ====
////////////////////////////////////////
// Trace-side types for records and counters
////////////////////////////////////////

`default_nettype none

`include "trace_cfg.svh"

package trace_pkg;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // Per-class retirement count
  typedef logic [`TRACE_CNT_WIDTH-1:0] event_cnt_t;

  // Cycle stamp attached to each record
  typedef logic [`TRACE_CYCLE_WIDTH-1:0] cycle_stamp_t;

endpackage

`default_nettype wire

// ==== verilog/retire_classifier.sv ====
////////////////////////////////////////
// Decodes each retired RV32IM instruction into
// its class and registers the trace fields
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module retire_classifier
  import rv_instr_pkg::*;
  import trace_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  wire logic         trace_en_i,
  input  wire logic         retire_valid_i,
  input  wire logic [31:0]  retire_pc_i,
  input  wire logic [31:0]  retire_instr_i,
  input  wire logic [31:0]  retire_rd_wdata_i,
  input  wire logic [31:0]  retire_mem_addr_i,
  input  wire logic [31:0]  retire_mem_wdata_i,
  input  wire logic [31:0]  retire_mem_rdata_i,
  output logic              cls_valid_o,
  output instr_class_e      cls_class_o,
  output logic [31:0]       cls_pc_o,
  output logic [31:0]       cls_instr_o,
  output reg_idx_t          cls_rd_o,
  output logic              cls_rd_we_o,
  output logic [31:0]       cls_rd_wdata_o,
  output logic              cls_mem_we_o,
  output logic [31:0]       cls_mem_addr_o,
  output logic [31:0]       cls_mem_data_o
);

  logic [6:0]   opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  reg_idx_t     rd_field;
  instr_class_e instr_class;
  logic         writes_rd;
  logic         rd_we;
  logic         mem_we;
  logic [31:0]  mem_addr;
  logic [31:0]  mem_data;
  logic         capture;

  assign opcode   = retire_instr_i[6:0];
  assign funct3   = retire_instr_i[14:12];
  assign funct7   = retire_instr_i[31:25];
  assign rd_field = retire_instr_i[11:7];

  ////////////////////////////////////////
  // Class decode
  ////////////////////////////////////////
  // Every opcode constant ends in 2'b11, so other low bits fall to INVALID
  always_comb begin
    instr_class = INVALID;
    case (opcode)
      OPC_LUI,
      OPC_AUIPC: instr_class = UPPER;
      OPC_JAL:   instr_class = JUMP;
      OPC_JALR: begin
        if (funct3 == 3'b000) instr_class = JUMP;
      end
      OPC_BRANCH: begin
        if (funct3 != 3'b010 && funct3 != 3'b011) instr_class = BRANCH;
      end
      OPC_LOAD: begin
        // Sizes 3, 6 and 7 are not RV32I loads
        if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) instr_class = LOAD;
      end
      OPC_STORE: begin
        if (!funct3[2] && funct3[1:0] != 2'b11) instr_class = STORE;
      end
      OPC_OPIMM: begin
        if (funct3 == FUNCT3_SLL) begin
          if (funct7 == FUNCT7_BASE) instr_class = ALU;
        end else if (funct3 == FUNCT3_SRL_SRA) begin
          if (funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT) instr_class = ALU;
        end else begin
          instr_class = ALU;
        end
      end
      OPC_OP: begin
        if (funct7 == FUNCT7_MULDIV) begin
          instr_class = MULDIV;
        end else if (funct7 == FUNCT7_BASE) begin
          instr_class = ALU;
        end else if (funct7 == FUNCT7_ALT &&
                     (funct3 == FUNCT3_ADD_SUB || funct3 == FUNCT3_SRL_SRA)) begin
          instr_class = ALU;
        end
      end
      OPC_SYSTEM: begin
        if (funct3 == FUNCT3_PRIV) begin
          if (retire_instr_i == INSTR_ECALL || retire_instr_i == INSTR_EBREAK ||
              retire_instr_i == INSTR_MRET  || retire_instr_i == INSTR_DRET   ||
              retire_instr_i == INSTR_WFI) begin
            instr_class = SYSTEM;
          end
        end else if (funct3 != 3'b100) begin
          instr_class = CSR;
        end
      end
      OPC_MISCMEM: begin
        if (funct3 == FUNCT3_FENCE) instr_class = SYSTEM;
      end
      default: instr_class = INVALID;
    endcase
  end

  // Register write-back and memory fields
  always_comb begin
    writes_rd = instr_class inside {ALU, UPPER, JUMP, LOAD, CSR, MULDIV};
    rd_we     = writes_rd && (rd_field != 5'd0);
    mem_we    = (instr_class == STORE);
    mem_addr  = '0;
    mem_data  = '0;
    if (instr_class == LOAD) begin
      mem_addr = retire_mem_addr_i;
      mem_data = retire_mem_rdata_i;
    end else if (instr_class == STORE) begin
      mem_addr = retire_mem_addr_i;
      mem_data = retire_mem_wdata_i;
    end
  end

  assign capture = retire_valid_i & trace_en_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cls_valid_o <= 1'b0;
    end else begin
      cls_valid_o <= capture;
    end
  end

  // Payload only moves with a strobe
  always_ff @(posedge clk_i) begin
    if (capture) begin
      cls_class_o    <= instr_class;
      cls_pc_o       <= retire_pc_i;
      cls_instr_o    <= retire_instr_i;
      cls_rd_o       <= rd_we ? rd_field : 5'd0;
      cls_rd_we_o    <= rd_we;
      cls_rd_wdata_o <= rd_we ? retire_rd_wdata_i : 32'd0;
      cls_mem_we_o   <= mem_we;
      cls_mem_addr_o <= mem_addr;
      cls_mem_data_o <= mem_data;
    end
  end

  // No classified strobe without a retirement one cycle earlier
  a_valid_follows_retire : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !retire_valid_i |=> !cls_valid_o);

  a_rd_we_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cls_valid_o && cls_rd_we_o) |-> (cls_rd_o != 5'd0));

endmodule

`default_nettype wire

// ==== verilog/class_event_counter.sv ====
////////////////////////////////////////
// Saturating retirement counter for one class
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module class_event_counter
  import trace_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic hit_i,
  output event_cnt_t count_o
);

  event_cnt_t count_q;
  logic       at_max;

  // Hold at all-ones rather than wrap
  assign at_max = &count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (hit_i && !at_max) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

  // Monotonic between resets, including at saturation
  a_count_monotonic : assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q >= $past(count_q));

endmodule

`default_nettype wire

// ==== verilog/trace_record_packer.sv ====
////////////////////////////////////////
// Stamps classified retirements with the cycle
// count and registers the outgoing trace record
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trace_record_packer
  import rv_instr_pkg::*;
  import trace_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  wire logic         cls_valid_i,
  input  instr_class_e      cls_class_i,
  input  wire logic [31:0]  cls_pc_i,
  input  wire logic [31:0]  cls_instr_i,
  input  reg_idx_t          cls_rd_i,
  input  wire logic         cls_rd_we_i,
  input  wire logic [31:0]  cls_rd_wdata_i,
  input  wire logic         cls_mem_we_i,
  input  wire logic [31:0]  cls_mem_addr_i,
  input  wire logic [31:0]  cls_mem_data_i,
  output logic              rec_valid_o,
  output logic [31:0]       rec_pc_o,
  output logic [31:0]       rec_instr_o,
  output instr_class_e      rec_class_o,
  output reg_idx_t          rec_rd_o,
  output logic              rec_rd_we_o,
  output logic [31:0]       rec_rd_wdata_o,
  output logic              rec_mem_we_o,
  output logic [31:0]       rec_mem_addr_o,
  output logic [31:0]       rec_mem_data_o,
  output cycle_stamp_t      rec_cycle_o
);

  cycle_stamp_t cycle_q;

  ////////////////////////////////////////
  // Free-running cycle stamp
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  // Record register, stamp is the count seen at the capturing edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_valid_o    <= 1'b0;
      rec_pc_o       <= '0;
      rec_instr_o    <= '0;
      rec_class_o    <= ALU;
      rec_rd_o       <= '0;
      rec_rd_we_o    <= 1'b0;
      rec_rd_wdata_o <= '0;
      rec_mem_we_o   <= 1'b0;
      rec_mem_addr_o <= '0;
      rec_mem_data_o <= '0;
      rec_cycle_o    <= '0;
    end else begin
      rec_valid_o <= cls_valid_i;
      if (cls_valid_i) begin
        rec_pc_o       <= cls_pc_i;
        rec_instr_o    <= cls_instr_i;
        rec_class_o    <= cls_class_i;
        rec_rd_o       <= cls_rd_i;
        rec_rd_we_o    <= cls_rd_we_i;
        rec_rd_wdata_o <= cls_rd_wdata_i;
        rec_mem_we_o   <= cls_mem_we_i;
        rec_mem_addr_o <= cls_mem_addr_i;
        rec_mem_data_o <= cls_mem_data_i;
        rec_cycle_o    <= cycle_q;
      end
    end
  end

  // A published record is fully defined back to the retirement port
  a_record_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rec_valid_o |-> !$isunknown({rec_pc_o, rec_instr_o, rec_class_o, rec_rd_o,
                                 rec_rd_we_o, rec_rd_wdata_o, rec_mem_we_o,
                                 rec_mem_addr_o, rec_mem_data_o, rec_cycle_o}));

endmodule

`default_nettype wire

// ==== verilog/retire_tracer.sv ====
////////////////////////////////////////
// Retirement monitor top with class counters
// and a trace record output
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "trace_cfg.svh"

module retire_tracer
  import rv_instr_pkg::*;
  import trace_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  wire logic         trace_en_i,
  input  wire logic         retire_valid_i,
  input  wire logic [31:0]  retire_pc_i,
  input  wire logic [31:0]  retire_instr_i,
  input  wire logic [31:0]  retire_rd_wdata_i,
  input  wire logic [31:0]  retire_mem_addr_i,
  input  wire logic [31:0]  retire_mem_wdata_i,
  input  wire logic [31:0]  retire_mem_rdata_i,
  input  wire logic [3:0]   cnt_sel_i,
  output event_cnt_t        cnt_o,
  output logic              rec_valid_o,
  output logic [31:0]       rec_pc_o,
  output logic [31:0]       rec_instr_o,
  output instr_class_e      rec_class_o,
  output reg_idx_t          rec_rd_o,
  output logic              rec_rd_we_o,
  output logic [31:0]       rec_rd_wdata_o,
  output logic              rec_mem_we_o,
  output logic [31:0]       rec_mem_addr_o,
  output logic [31:0]       rec_mem_data_o,
  output cycle_stamp_t      rec_cycle_o
);

  logic         cls_valid;
  instr_class_e cls_class;
  logic [31:0]  cls_pc;
  logic [31:0]  cls_instr;
  reg_idx_t     cls_rd;
  logic         cls_rd_we;
  logic [31:0]  cls_rd_wdata;
  logic         cls_mem_we;
  logic [31:0]  cls_mem_addr;
  logic [31:0]  cls_mem_data;

  logic [`TRACE_NUM_CLASSES-1:0] class_hit;
  event_cnt_t                    class_cnt [`TRACE_NUM_CLASSES];

  retire_classifier u_classifier (
    .clk_i,
    .rst_ni,
    .trace_en_i,
    .retire_valid_i,
    .retire_pc_i,
    .retire_instr_i,
    .retire_rd_wdata_i,
    .retire_mem_addr_i,
    .retire_mem_wdata_i,
    .retire_mem_rdata_i,
    .cls_valid_o    (cls_valid),
    .cls_class_o    (cls_class),
    .cls_pc_o       (cls_pc),
    .cls_instr_o    (cls_instr),
    .cls_rd_o       (cls_rd),
    .cls_rd_we_o    (cls_rd_we),
    .cls_rd_wdata_o (cls_rd_wdata),
    .cls_mem_we_o   (cls_mem_we),
    .cls_mem_addr_o (cls_mem_addr),
    .cls_mem_data_o (cls_mem_data)
  );

  ////////////////////////////////////////
  // One hit strobe and counter per class
  ////////////////////////////////////////
  for (genvar k = 0; k < `TRACE_NUM_CLASSES; k++) begin : g_class_cnt
    localparam logic [3:0] CLASS_IDX = 4'(k);

    assign class_hit[k] = cls_valid && (cls_class == instr_class_e'(CLASS_IDX));

    class_event_counter u_counter (
      .clk_i,
      .rst_ni,
      .hit_i   (class_hit[k]),
      .count_o (class_cnt[k])
    );
  end

  // Readout, out-of-range selections read zero
  always_comb begin
    cnt_o = '0;
    if (cnt_sel_i < 4'(`TRACE_NUM_CLASSES)) begin
      cnt_o = class_cnt[cnt_sel_i];
    end
  end

  trace_record_packer u_packer (
    .clk_i,
    .rst_ni,
    .cls_valid_i    (cls_valid),
    .cls_class_i    (cls_class),
    .cls_pc_i       (cls_pc),
    .cls_instr_i    (cls_instr),
    .cls_rd_i       (cls_rd),
    .cls_rd_we_i    (cls_rd_we),
    .cls_rd_wdata_i (cls_rd_wdata),
    .cls_mem_we_i   (cls_mem_we),
    .cls_mem_addr_i (cls_mem_addr),
    .cls_mem_data_i (cls_mem_data),
    .rec_valid_o,
    .rec_pc_o,
    .rec_instr_o,
    .rec_class_o,
    .rec_rd_o,
    .rec_rd_we_o,
    .rec_rd_wdata_o,
    .rec_mem_we_o,
    .rec_mem_addr_o,
    .rec_mem_data_o,
    .rec_cycle_o
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
////////////////////////////////////////
// Testbench clock and reset source
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release away from the edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/retire_tracer_tb.sv ====
////////////////////////////////////////
// Directed tests for the retirement monitor
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "trace_cfg.svh"

module retire_tracer_tb
  import rv_instr_pkg::*;
  import trace_pkg::*;
;

  localparam int NUM_WORDS = 27;

  // One word per class plus x0 writes and malformed encodings
  localparam logic [31:0] DIRECTED_WORDS [NUM_WORDS] = '{
    32'h002082b3, 32'h00000013, 32'h00208033, 32'h123451b7,
    32'h00001217, 32'h010000ef, 32'h00008067, 32'h00208463,
    32'h00412303, 32'h00014383, 32'h00512423, 32'h00510023,
    32'h30009473, 32'h3040e4f3, 32'h00000073, 32'h00100073,
    32'h30200073, 32'h7b200073, 32'h10500073, 32'h0ff0000f,
    32'h02208533, 32'h0220d5b3, 32'hffffffff, 32'h00000000,
    32'h00413303, 32'h00417303, 32'h00513423
  };

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] rd_wdata;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic [31:0] issue;
  } retire_rec_t;

  logic         clk;
  logic         rst_n;
  logic         trace_en;
  logic         retire_valid;
  logic [31:0]  retire_pc;
  logic [31:0]  retire_instr;
  logic [31:0]  retire_rd_wdata;
  logic [31:0]  retire_mem_addr;
  logic [31:0]  retire_mem_wdata;
  logic [31:0]  retire_mem_rdata;
  logic [3:0]   cnt_sel;
  event_cnt_t   cnt;
  logic         rec_valid;
  logic [31:0]  rec_pc;
  logic [31:0]  rec_instr;
  instr_class_e rec_class;
  reg_idx_t     rec_rd;
  logic         rec_rd_we;
  logic [31:0]  rec_rd_wdata;
  logic         rec_mem_we;
  logic [31:0]  rec_mem_addr;
  logic [31:0]  rec_mem_data;
  cycle_stamp_t rec_cycle;

  integer       seed;
  logic [31:0]  tb_cycle = '0;
  logic [31:0]  next_pc;
  retire_rec_t  pending [$];
  event_cnt_t   tally [`TRACE_NUM_CLASSES];
  logic         stamp_seen;
  logic [31:0]  last_stamp;
  logic [31:0]  last_issue;
  string        item;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  retire_tracer dut_i (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .trace_en_i         (trace_en),
    .retire_valid_i     (retire_valid),
    .retire_pc_i        (retire_pc),
    .retire_instr_i     (retire_instr),
    .retire_rd_wdata_i  (retire_rd_wdata),
    .retire_mem_addr_i  (retire_mem_addr),
    .retire_mem_wdata_i (retire_mem_wdata),
    .retire_mem_rdata_i (retire_mem_rdata),
    .cnt_sel_i          (cnt_sel),
    .cnt_o              (cnt),
    .rec_valid_o        (rec_valid),
    .rec_pc_o           (rec_pc),
    .rec_instr_o        (rec_instr),
    .rec_class_o        (rec_class),
    .rec_rd_o           (rec_rd),
    .rec_rd_we_o        (rec_rd_we),
    .rec_rd_wdata_o     (rec_rd_wdata),
    .rec_mem_we_o       (rec_mem_we),
    .rec_mem_addr_o     (rec_mem_addr),
    .rec_mem_data_o     (rec_mem_data),
    .rec_cycle_o        (rec_cycle)
  );

  always @(posedge clk) tb_cycle <= tb_cycle + 32'd1;

  ////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////
  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_class(input instr_class_e got, input instr_class_e exp, input string what);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch at %0t: %s %s got %s expected %s",
                                $time, item, what, got.name(), exp.name()));
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch at %0t: %s %s got %h expected %h",
                                $time, item, what, got, exp));
    end
  endtask

  task automatic check_count(input event_cnt_t got, input event_cnt_t exp, input string what);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch at %0t: %s %s got %0d expected %0d",
                                $time, item, what, got, exp));
    end
  endtask

  // Reference classes straight from the RV32IM encoding tables
  function automatic instr_class_e ref_class(input logic [31:0] w);
    logic [2:0]   f3;
    logic [6:0]   f7;
    instr_class_e c;
    f3 = w[14:12];
    f7 = w[31:25];
    c  = INVALID;
    if (w[1:0] == 2'b11) begin
      case (w[6:0])
        OPC_LUI, OPC_AUIPC: c = UPPER;
        OPC_JAL:     c = JUMP;
        OPC_JALR:    if (f3 == 3'd0) c = JUMP;
        OPC_BRANCH:  if (f3 != 3'd2 && f3 != 3'd3) c = BRANCH;
        OPC_LOAD:    if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) c = LOAD;
        OPC_STORE:   if (f3 <= 3'd2) c = STORE;
        OPC_OPIMM: begin
          if (f3 == 3'd1) c = (f7 == 7'h00) ? ALU : INVALID;
          else if (f3 == 3'd5) c = (f7 == 7'h00 || f7 == 7'h20) ? ALU : INVALID;
          else c = ALU;
        end
        OPC_OP: begin
          if (f7 == 7'h01) c = MULDIV;
          else if (f7 == 7'h00) c = ALU;
          else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) c = ALU;
        end
        OPC_SYSTEM: begin
          if (f3 == 3'd0) begin
            if (w inside {32'h00000073, 32'h00100073, 32'h30200073,
                          32'h7b200073, 32'h10500073}) c = SYSTEM;
          end else if (f3 != 3'd4) begin
            c = CSR;
          end
        end
        OPC_MISCMEM: if (f3 == 3'd0) c = SYSTEM;
        default:     c = INVALID;
      endcase
    end
    return c;
  endfunction

  ////////////////////////////////////////
  // Record scoreboard
  ////////////////////////////////////////
  task automatic score_record();
    retire_rec_t  r;
    instr_class_e c;
    logic         we;
    logic [31:0]  exp_addr;
    logic [31:0]  exp_data;
    if (pending.size() == 0) begin
      stop_with_error($sformatf("Unexpected trace record at %0t with no retirement pending",
                                $time));
    end else begin
      r = pending.pop_front();
      c = ref_class(r.instr);
      item = $sformatf("record for instr %h", r.instr);
      we = (c inside {ALU, UPPER, JUMP, LOAD, CSR, MULDIV}) && (r.instr[11:7] != 5'd0);
      exp_addr = (c == LOAD || c == STORE) ? r.mem_addr : 32'd0;
      exp_data = (c == LOAD) ? r.mem_rdata : ((c == STORE) ? r.mem_wdata : 32'd0);
      check_class(rec_class, c, "class");
      check_word(rec_pc, r.pc, "pc");
      check_word(rec_instr, r.instr, "instr");
      check_word({31'b0, rec_rd_we}, {31'b0, we}, "rd_we");
      check_word(rec_rd_wdata, we ? r.rd_wdata : 32'd0, "rd_wdata");
      if (we) check_word({27'b0, rec_rd}, {27'b0, r.instr[11:7]}, "rd");
      check_word({31'b0, rec_mem_we}, {31'b0, c == STORE}, "mem_we");
      check_word(rec_mem_addr, exp_addr, "mem_addr");
      check_word(rec_mem_data, exp_data, "mem_data");
      check_word(tb_cycle - r.issue, 32'd2, "latency");
      if (stamp_seen) check_word(rec_cycle - last_stamp, r.issue - last_issue, "stamp delta");
      stamp_seen = 1'b1;
      last_stamp = rec_cycle;
      last_issue = r.issue;
    end
  endtask

  // Records sampled mid-cycle, away from both edges of the DUT
  always @(negedge clk) begin
    if (rst_n && rec_valid) score_record();
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  task automatic retire(input logic [31:0] word);
    retire_rec_t r;
    int          idx;
    r.pc        = next_pc;
    r.instr     = word;
    r.rd_wdata  = $random(seed);
    r.mem_addr  = $random(seed);
    r.mem_wdata = $random(seed);
    r.mem_rdata = $random(seed);
    r.issue     = tb_cycle;
    next_pc = next_pc + 32'd4;
    retire_valid     = 1'b1;
    retire_pc        = r.pc;
    retire_instr     = r.instr;
    retire_rd_wdata  = r.rd_wdata;
    retire_mem_addr  = r.mem_addr;
    retire_mem_wdata = r.mem_wdata;
    retire_mem_rdata = r.mem_rdata;
    if (trace_en) begin
      pending.push_back(r);
      idx = int'(ref_class(word));
      tally[idx] = tally[idx] + 1'b1;
    end
    @(posedge clk);
    #1;
    retire_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_records_drained();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (pending.size() != 0 && waited > 10) begin
        stop_with_error($sformatf("Timeout at %0t: no trace record arrived within 10 cycles",
                                  $time));
      end
    end while (pending.size() != 0);
    #1;
  endtask

  // Walks every selection, the out-of-range ones must read zero
  task automatic verify_counters();
    int sel;
    for (sel = 0; sel < 16; sel++) begin
      cnt_sel = 4'(sel);
      item = $sformatf("counter select %0d", sel);
      @(negedge clk);
      if (sel < `TRACE_NUM_CLASSES) check_count(cnt, tally[sel], "count");
      else check_count(cnt, '0, "count");
      @(posedge clk);
      #1;
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic class_sweep();
    int i;
    for (i = 0; i < NUM_WORDS; i++) begin
      retire(DIRECTED_WORDS[i]);
      wait_records_drained();
    end
  endtask

  task automatic back_to_back_stream();
    int i;
    for (i = 0; i < 6; i++) retire(DIRECTED_WORDS[i]);
    idle_cycles(3);
    retire(DIRECTED_WORDS[8]);
    idle_cycles(1);
    retire(DIRECTED_WORDS[10]);
    idle_cycles(2);
    retire(DIRECTED_WORDS[20]);
    wait_records_drained();
  endtask

  task automatic random_mix_counts();
    int          i;
    int          idx;
    logic [31:0] w;
    for (i = 0; i < 200; i++) begin
      idx = ($random(seed) & 32'h7fff_ffff) % NUM_WORDS;
      w = DIRECTED_WORDS[idx];
      // System words are fully encoded, keep their rd field
      if (ref_class(w) != SYSTEM) w[11:7] = 5'($random(seed));
      retire(w);
      if (($random(seed) & 3) == 0) idle_cycles(1);
    end
    wait_records_drained();
    verify_counters();
  endtask

  task automatic disabled_tracing();
    int i;
    trace_en = 1'b0;
    for (i = 0; i < 5; i++) retire(DIRECTED_WORDS[i * 4]);
    idle_cycles(4);
    verify_counters();
    trace_en = 1'b1;
    retire(DIRECTED_WORDS[10]);
    wait_records_drained();
    verify_counters();
  endtask

  initial begin
    int waited;
    seed             = 32'h43f6;
    trace_en         = 1'b1;
    retire_valid     = 1'b0;
    retire_pc        = '0;
    retire_instr     = '0;
    retire_rd_wdata  = '0;
    retire_mem_addr  = '0;
    retire_mem_wdata = '0;
    retire_mem_rdata = '0;
    cnt_sel          = '0;
    next_pc          = 32'h8000_0000;
    stamp_seen       = 1'b0;
    last_stamp       = '0;
    last_issue       = '0;
    item             = "";
    for (int k = 0; k < `TRACE_NUM_CLASSES; k++) tally[k] = '0;
    waited = 0;
    while (rst_n !== 1'b1) begin
      if (waited == 20) stop_with_error("Reset was never released");
      @(posedge clk);
      waited++;
    end
    idle_cycles(1);
    verify_counters();
    class_sweep();
    back_to_back_stream();
    random_mix_counts();
    disabled_tracing();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/rv_instr_pkg.sv
verilog/trace_pkg.sv
verilog/retire_classifier.sv
verilog/class_event_counter.sv
verilog/trace_record_packer.sv
verilog/retire_tracer.sv
tests/tb_clock_gen.sv
tests/retire_tracer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := retire_tracer_tb
FILE_LIST := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard verilog/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
